/* rtl/access_ctrl.sv */
`timescale 1ns/1ps
`include "dms_macros.svh"

module access_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    output logic                   ack,
    input  logic                   we,
    input  dms_pkg::word_t         addr,
    input  dms_pkg::word_t         wdata,
    input  dms_pkg::access_width_t width,
    input  logic                   load_uns,
    output dms_pkg::region_t       region,
    output logic [13:0]            word_addr,
    output logic [1:0]             offset,
    output dms_pkg::mmio_idx_t     mmio_idx,
    output dms_pkg::access_width_t acc_width,
    output logic                   acc_uns,
    output logic                   access,
    output logic                   store,
    output dms_pkg::byte_en_t      byte_en,
    output dms_pkg::word_t         wdata_aligned,
    output logic                   capture
);
    import dms_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_DONE
    } state_t;

    state_t        state;
    state_t        state_nxt;
    logic          we_q;
    word_t         addr_q;
    word_t         wdata_q;
    access_width_t width_q;
    logic          uns_q;
    byte_en_t      lane_mask;

    // --------------------
    // four-phase handshake FSM
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (req) state_nxt = ST_ACCESS;
            ST_ACCESS:  state_nxt = ST_RESPOND;
            ST_RESPOND: state_nxt = ST_DONE;
            // stay here while the requester still holds req
            ST_DONE:    if (!req) state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && req) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
            width_q <= width;
            uns_q   <= load_uns;
        end
    end

    assign access  = (state == ST_ACCESS);
    assign store   = access && we_q;
    assign capture = (state == ST_RESPOND);
    assign ack     = (state == ST_DONE);

    // --------------------
    // address decode
    always_comb begin
        case (addr_q[31:30])
            `DMS_DMEM_RANGE: region = REGION_DMEM;
            `DMS_MMIO_RANGE: region = REGION_MMIO;
            default:         region = REGION_NONE;
        endcase
    end

    assign word_addr = addr_q[15:2];
    assign offset    = addr_q[1:0];
    assign mmio_idx  = addr_q[4:2];
    assign acc_width = width_q;
    assign acc_uns   = uns_q;

    // --------------------
    // store lane alignment
    always_comb begin
        case (width_q)
            BYTE:    lane_mask = 4'b0001;
            HALF:    lane_mask = 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    end

    // lanes only reach data memory, mmio writes use the store strobe
    assign byte_en = (we_q && (region == REGION_DMEM)) ? (lane_mask << offset) : '0;
    assign wdata_aligned = wdata_q << {offset, 3'b000};

    // requester must keep half and word accesses naturally aligned
    assert property (@(posedge clk) disable iff (rst)
        access && (acc_width == HALF) |-> !offset[0]);
    assert property (@(posedge clk) disable iff (rst)
        access && (acc_width == WORD) |-> (offset == 2'b00));

    // ack only answers a req held high from capture until the response
    assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req, 3) && $past(req, 2) && $past(req, 1));

endmodule

/* rtl/data_mem_space.sv */
`timescale 1ns/1ps

module data_mem_space (
    input  logic                   clk,
    input  logic                   rst,
    // requester handshake
    input  logic                   req,
    output logic                   ack,
    input  logic                   we,
    input  dms_pkg::word_t         addr,
    input  dms_pkg::word_t         wdata,
    input  dms_pkg::access_width_t width,
    input  logic                   load_uns,
    output dms_pkg::word_t         rdata,
    // uart side
    input  logic [7:0]             uart_rx_data,
    input  logic                   uart_rx_valid,
    input  logic                   uart_tx_ready,
    output logic [7:0]             uart_tx_data,
    output logic                   store_to_uart,
    output logic                   load_from_uart,
    // counters
    input  dms_pkg::word_t         cycle_cnt,
    input  dms_pkg::word_t         instr_cnt,
    output logic                   reset_cnt
);
    import dms_pkg::*;

    region_t       region;
    logic [13:0]   word_addr;
    logic [1:0]    offset;
    mmio_idx_t     mmio_idx;
    access_width_t acc_width;
    logic          acc_uns;
    logic          access;
    logic          store;
    byte_en_t      byte_en;
    word_t         wdata_aligned;
    logic          capture;
    word_t         dmem_rdata;
    word_t         mmio_rdata;
    logic          dmem_en;
    logic          mmio_en;

    // per-target enables
    assign dmem_en = access && (region == REGION_DMEM);
    assign mmio_en = access && (region == REGION_MMIO);

    // --------------------
    // control and store path
    access_ctrl u_access_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .ack           (ack),
        .we            (we),
        .addr          (addr),
        .wdata         (wdata),
        .width         (width),
        .load_uns      (load_uns),
        .region        (region),
        .word_addr     (word_addr),
        .offset        (offset),
        .mmio_idx      (mmio_idx),
        .acc_width     (acc_width),
        .acc_uns       (acc_uns),
        .access        (access),
        .store         (store),
        .byte_en       (byte_en),
        .wdata_aligned (wdata_aligned),
        .capture       (capture)
    );

    dmem_ram u_dmem_ram (
        .clk       (clk),
        .en        (dmem_en),
        .byte_en   (byte_en),
        .word_addr (word_addr),
        .wdata     (wdata_aligned),
        .rdata     (dmem_rdata)
    );

    mmio_regs u_mmio_regs (
        .clk            (clk),
        .rst            (rst),
        .en             (mmio_en),
        .store          (store),
        .mmio_idx       (mmio_idx),
        .wdata          (wdata_aligned),
        .uart_rx_data   (uart_rx_data),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .cycle_cnt      (cycle_cnt),
        .instr_cnt      (instr_cnt),
        .rdata          (mmio_rdata),
        .uart_tx_data   (uart_tx_data),
        .store_to_uart  (store_to_uart),
        .load_from_uart (load_from_uart),
        .reset_cnt      (reset_cnt)
    );

    // --------------------
    // load return path
    load_align u_load_align (
        .clk       (clk),
        .rst       (rst),
        .capture   (capture),
        .region    (region),
        .offset    (offset),
        .width     (acc_width),
        .load_uns  (acc_uns),
        .dmem_data (dmem_rdata),
        .mmio_data (mmio_rdata),
        .rdata     (rdata)
    );

endmodule

/* rtl/dmem_ram.sv */
`timescale 1ns/1ps
`include "dms_macros.svh"

module dmem_ram #(
    parameter int DEPTH = `DMS_DMEM_WORDS
) (
    input  logic              clk,
    input  logic              en,
    input  dms_pkg::byte_en_t byte_en,
    input  logic [13:0]       word_addr,
    input  dms_pkg::word_t    wdata,
    output dms_pkg::word_t    rdata
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [31:0]   mem [DEPTH];
    logic [AW-1:0] idx;

    assign idx = word_addr[AW-1:0];

    // --------------------
    // byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (en && byte_en[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[idx];
        end
    end

    // decoded dmem accesses must land inside the array
    assert property (@(posedge clk)
        en |-> (word_addr < DEPTH));

endmodule

/* rtl/dms_macros.svh */
`ifndef DMS_MACROS_SVH
`define DMS_MACROS_SVH

// --------------------
// address map

// value of addr[31:30] for data memory
`define DMS_DMEM_RANGE 2'b00
// value of addr[31:30] for memory-mapped I/O
`define DMS_MMIO_RANGE 2'b01

// --------------------
// mmio register slots

// rx valid and tx ready flags
`define DMS_MMIO_STATUS    3'd0
// last byte from the UART receiver
`define DMS_MMIO_RX_DATA   3'd1
// byte for the UART transmitter
`define DMS_MMIO_TX_DATA   3'd2
// bit 0 holds the counters in reset
`define DMS_MMIO_CNT_RESET 3'd4
`define DMS_MMIO_CYCLE_CNT 3'd5
`define DMS_MMIO_INSTR_CNT 3'd6

// --------------------
// data memory

// default depth in 32-bit words
`define DMS_DMEM_WORDS 256

`endif

/* rtl/dms_pkg.sv */
package dms_pkg;

    // --------------------
    // data and address words

    // one bus word, used for addresses as well as data
    typedef logic [31:0] word_t;

    // write strobe per byte lane, bit 0 is the lowest byte
    typedef logic [3:0] byte_en_t;

    // --------------------
    // access attributes

    // encoding follows the low bits of the RISC-V load/store funct3
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } access_width_t;

    // target picked from address bits 31:30
    typedef enum logic [1:0] {
        REGION_DMEM = 2'd0,
        REGION_MMIO = 2'd1,
        REGION_NONE = 2'd2
    } region_t;

    // mmio register slot, address bits 4:2
    typedef logic [2:0] mmio_idx_t;

endpackage

/* rtl/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   capture,
    input  dms_pkg::region_t       region,
    input  logic [1:0]             offset,
    input  dms_pkg::access_width_t width,
    input  logic                   load_uns,
    input  dms_pkg::word_t         dmem_data,
    input  dms_pkg::word_t         mmio_data,
    output dms_pkg::word_t         rdata
);
    import dms_pkg::*;

    word_t src;
    word_t shifted;
    word_t result;

    // source select, unmapped reads as zero
    always_comb begin
        case (region)
            REGION_DMEM: src = dmem_data;
            REGION_MMIO: src = mmio_data;
            default:     src = '0;
        endcase
    end

    // addressed lane down to bit 0
    assign shifted = src >> {offset, 3'b000};

    // --------------------
    // mask and extend
    always_comb begin
        case (width)
            BYTE: begin
                result = load_uns ? {24'd0, shifted[7:0]}
                                  : {{24{shifted[7]}}, shifted[7:0]};
            end
            HALF: begin
                result = load_uns ? {16'd0, shifted[15:0]}
                                  : {{16{shifted[15]}}, shifted[15:0]};
            end
            default: begin
                result = shifted;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (capture) begin
            rdata <= result;
        end
    end

endmodule

/* rtl/mmio_regs.sv */
`timescale 1ns/1ps
`include "dms_macros.svh"

module mmio_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               store,
    input  dms_pkg::mmio_idx_t mmio_idx,
    input  dms_pkg::word_t     wdata,
    input  logic [7:0]         uart_rx_data,
    input  logic               uart_rx_valid,
    input  logic               uart_tx_ready,
    input  dms_pkg::word_t     cycle_cnt,
    input  dms_pkg::word_t     instr_cnt,
    output dms_pkg::word_t     rdata,
    output logic [7:0]         uart_tx_data,
    output logic               store_to_uart,
    output logic               load_from_uart,
    output logic               reset_cnt
);
    logic wr_en;
    logic rd_en;

    assign wr_en = en && store;
    assign rd_en = en && !store;

    // --------------------
    // uart strobes, one cycle wide with the access
    assign store_to_uart  = wr_en && (mmio_idx == `DMS_MMIO_TX_DATA);
    assign load_from_uart = rd_en && (mmio_idx == `DMS_MMIO_RX_DATA);

    // --------------------
    // write registers
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_tx_data <= 8'h00;
            reset_cnt    <= 1'b0;
        end else if (wr_en) begin
            case (mmio_idx)
                `DMS_MMIO_TX_DATA:   uart_tx_data <= wdata[7:0];
                `DMS_MMIO_CNT_RESET: reset_cnt    <= wdata[0];
                default: ;
            endcase
        end
    end

    // --------------------
    // read mux, registered on any access
    always_ff @(posedge clk) begin
        if (en) begin
            case (mmio_idx)
                `DMS_MMIO_STATUS: begin
                    rdata <= {30'd0, uart_rx_valid, uart_tx_ready};
                end
                `DMS_MMIO_RX_DATA: begin
                    rdata <= {24'd0, uart_rx_data};
                end
                `DMS_MMIO_CYCLE_CNT: begin
                    rdata <= cycle_cnt;
                end
                `DMS_MMIO_INSTR_CNT: begin
                    rdata <= instr_cnt;
                end
                // tx data and counter reset are write only
                default: begin
                    rdata <= '0;
                end
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the data memory space testbench with Verilator

TOP=tb_data_mem_space
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sources.f */
+incdir+rtl
rtl/dms_pkg.sv
rtl/access_ctrl.sv
rtl/dmem_ram.sv
rtl/mmio_regs.sv
rtl/load_align.sv
rtl/data_mem_space.sv
verification/tb_data_mem_space.sv

/* verification/dms_tests.txt */
# name op(st/ld) addr width(0 byte,1 half,2 word) uns wdata rx_data rx_valid tx_ready
#   cycle_cnt instr_cnt exp_rdata exp_tx exp_reset_cnt (values in hex, flags in decimal)
sw_word      st 00000010 2 0 deadbeef 00 0 0 00000000 00000000 00000000 00 0
lw_word      ld 00000010 2 0 00000000 00 0 0 00000000 00000000 deadbeef 00 0
sb_off0      st 00000020 0 0 000000a5 00 0 0 00000000 00000000 00000000 00 0
sb_off1      st 00000021 0 0 ffffff7e 00 0 0 00000000 00000000 00000000 00 0
sb_off2      st 00000022 0 0 000000c3 00 0 0 00000000 00000000 00000000 00 0
sb_off3      st 00000023 0 0 00000081 00 0 0 00000000 00000000 00000000 00 0
lb_off0      ld 00000020 0 0 00000000 00 0 0 00000000 00000000 ffffffa5 00 0
lbu_off0     ld 00000020 0 1 00000000 00 0 0 00000000 00000000 000000a5 00 0
lb_off1      ld 00000021 0 0 00000000 00 0 0 00000000 00000000 0000007e 00 0
lb_off2      ld 00000022 0 0 00000000 00 0 0 00000000 00000000 ffffffc3 00 0
lbu_off2     ld 00000022 0 1 00000000 00 0 0 00000000 00000000 000000c3 00 0
lb_off3      ld 00000023 0 0 00000000 00 0 0 00000000 00000000 ffffff81 00 0
lbu_off3     ld 00000023 0 1 00000000 00 0 0 00000000 00000000 00000081 00 0
lw_bytes     ld 00000020 2 0 00000000 00 0 0 00000000 00000000 81c37ea5 00 0
sh_off0      st 00000030 1 0 00008001 00 0 0 00000000 00000000 00000000 00 0
sh_off2      st 00000032 1 0 5555f234 00 0 0 00000000 00000000 00000000 00 0
lh_off0      ld 00000030 1 0 00000000 00 0 0 00000000 00000000 ffff8001 00 0
lhu_off0     ld 00000030 1 1 00000000 00 0 0 00000000 00000000 00008001 00 0
lh_off2      ld 00000032 1 0 00000000 00 0 0 00000000 00000000 fffff234 00 0
lhu_off2     ld 00000032 1 1 00000000 00 0 0 00000000 00000000 0000f234 00 0
sb_tx        st 40000008 0 0 1234565a 00 0 0 00000000 00000000 00000000 5a 0
ld_status_rx ld 40000000 2 0 00000000 00 1 0 00000000 00000000 00000002 5a 0
ld_status_tx ld 40000000 2 0 00000000 00 0 1 00000000 00000000 00000001 5a 0
lw_rx_data   ld 40000004 2 0 00000000 9c 1 0 00000000 00000000 0000009c 5a 0
lb_rx_data   ld 40000004 0 0 00000000 9c 1 0 00000000 00000000 ffffff9c 5a 0
ld_cycle     ld 40000014 2 0 00000000 00 0 0 1234abcd 00000000 1234abcd 5a 0
ld_instr     ld 40000018 2 0 00000000 00 0 0 00000000 00c0ffee 00c0ffee 5a 0
ld_unused    ld 4000000c 2 0 00000000 00 0 0 00000000 00000000 00000000 5a 0
sw_unmapped  st 80000010 2 0 11111111 00 0 0 00000000 00000000 00000000 5a 0
lw_keep_dmem ld 00000010 2 0 00000000 00 0 0 00000000 00000000 deadbeef 5a 0
lw_unmapped  ld 80000010 2 0 00000000 00 0 0 00000000 00000000 00000000 5a 0
lw_region3   ld c0000020 2 0 00000000 00 0 0 00000000 00000000 00000000 5a 0
sw_cnt_set   st 40000010 2 0 00000001 00 0 0 00000000 00000000 00000000 5a 1
lw_cnt_hold  ld 00000020 2 0 00000000 00 0 0 00000000 00000000 81c37ea5 5a 1
sw_cnt_clr   st 40000010 2 0 fffffffe 00 0 0 00000000 00000000 00000000 5a 0

/* verification/tb_data_mem_space.sv */
`timescale 1ns/1ps

module tb_data_mem_space;
    import dms_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam int    RST_CYCLES = 3;
    localparam int    HS_LIMIT   = 10;
    localparam string TEST_FILE  = "verification/dms_tests.txt";

    logic          clk;
    logic          rst;
    logic          req;
    logic          ack;
    logic          we;
    word_t         addr;
    word_t         wdata;
    access_width_t width;
    logic          load_uns;
    word_t         rdata;
    logic [7:0]    uart_rx_data;
    logic          uart_rx_valid;
    logic          uart_tx_ready;
    logic [7:0]    uart_tx_data;
    logic          store_to_uart;
    logic          load_from_uart;
    word_t         cycle_cnt;
    word_t         instr_cnt;
    logic          reset_cnt;

    string lines[$];
    bit    loaded;
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    tx_pulses;
    int    rx_pulses;

    data_mem_space u_data_mem_space (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .ack            (ack),
        .we             (we),
        .addr           (addr),
        .wdata          (wdata),
        .width          (width),
        .load_uns       (load_uns),
        .rdata          (rdata),
        .uart_rx_data   (uart_rx_data),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .uart_tx_data   (uart_tx_data),
        .store_to_uart  (store_to_uart),
        .load_from_uart (load_from_uart),
        .cycle_cnt      (cycle_cnt),
        .instr_cnt      (instr_cnt),
        .reset_cnt      (reset_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // strobes span a whole cycle, so one falling edge sees each pulse
    always @(negedge clk) begin
        if (store_to_uart) begin
            tx_pulses++;
        end
        if (load_from_uart) begin
            rx_pulses++;
        end
    end

    // --------------------
    // test file
    task automatic read_tests();
        int    fd;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open test file %s", TEST_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------
    // one access over the full four-phase handshake
    task automatic run_test(input string line);
        logic [8*20-1:0] name_raw;
        logic [8*20-1:0] op;
        string           name;
        word_t           t_addr;
        word_t           t_wdata;
        word_t           t_rx_data;
        word_t           t_cycle;
        word_t           t_instr;
        word_t           exp_rdata;
        word_t           exp_tx;
        int              t_width;
        int              t_uns;
        int              t_rx_valid;
        int              t_tx_ready;
        int              exp_rst;
        int              fields;
        int              n;
        int              errs;
        int              exp_tx_pulses;
        int              exp_rx_pulses;
        logic            is_store;
        logic            is_mmio;
        fields = $sscanf(line, "%s %s %h %d %d %h %h %d %d %h %h %h %h %d",
                         name_raw, op, t_addr, t_width, t_uns, t_wdata, t_rx_data,
                         t_rx_valid, t_tx_ready, t_cycle, t_instr, exp_rdata, exp_tx,
                         exp_rst);
        name = string'(name_raw);
        errs = 0;
        tests_run++;
        if (fields != 14) begin
            $display("malformed test line: %s", line);
            tests_failed++;
            errors++;
            return;
        end
        // uart strobes follow from the address map
        is_store      = (op == "st");
        is_mmio       = (t_addr[31:30] == 2'b01);
        exp_tx_pulses = (is_store && is_mmio && t_addr[4:2] == 3'd2) ? 1 : 0;
        exp_rx_pulses = (!is_store && is_mmio && t_addr[4:2] == 3'd1) ? 1 : 0;

        @(negedge clk);
        we            = is_store;
        addr          = t_addr;
        wdata         = t_wdata;
        width         = access_width_t'(t_width);
        load_uns      = t_uns[0];
        uart_rx_data  = t_rx_data[7:0];
        uart_rx_valid = t_rx_valid[0];
        uart_tx_ready = t_tx_ready[0];
        cycle_cnt     = t_cycle;
        instr_cnt     = t_instr;
        tx_pulses     = 0;
        rx_pulses     = 0;
        req           = 1'b1;
        n = 0;
        while (!ack && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ack) begin
            $display("%s: ack did not rise within %0d cycles", name, HS_LIMIT);
            errs++;
        end else begin
            // three rising edges from request to ack
            if (n != 3) begin
                $display("Fail %s ack latency expected 3 actual %0d", name, n);
                errs++;
            end
            if (!is_store && rdata !== exp_rdata) begin
                $display("Fail %s rdata expected %h actual %h", name, exp_rdata, rdata);
                errs++;
            end
        end
        if (uart_tx_data !== exp_tx[7:0]) begin
            $display("Fail %s uart_tx_data expected %h actual %h", name, exp_tx[7:0],
                     uart_tx_data);
            errs++;
        end
        if (reset_cnt !== exp_rst[0]) begin
            $display("Fail %s reset_cnt expected %0d actual %b", name, exp_rst[0], reset_cnt);
            errs++;
        end

        req = 1'b0;
        n = 0;
        while (ack && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ack) begin
            $display("%s: ack stayed high after req fell", name);
            errs++;
        end
        if (tx_pulses != exp_tx_pulses) begin
            $display("Fail %s store_to_uart pulses expected %0d actual %0d", name,
                     exp_tx_pulses, tx_pulses);
            errs++;
        end
        if (rx_pulses != exp_rx_pulses) begin
            $display("Fail %s load_from_uart pulses expected %0d actual %0d", name,
                     exp_rx_pulses, rx_pulses);
            errs++;
        end

        if (errs == 0) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errs);
            tests_failed++;
        end
        errors += errs;
    endtask

    // --------------------
    // main sequence
    initial begin
        logic [43:0] after_rst;
        clk           = 1'b0;
        rst           = 1'b1;
        req           = 1'b0;
        we            = 1'b0;
        addr          = '0;
        wdata         = '0;
        width         = WORD;
        load_uns      = 1'b0;
        uart_rx_data  = 8'h00;
        uart_rx_valid = 1'b0;
        uart_tx_ready = 1'b0;
        cycle_cnt     = '0;
        instr_cnt     = '0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        read_tests();
        loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every output idle straight out of reset
        tests_run++;
        after_rst = {ack, store_to_uart, load_from_uart, reset_cnt, uart_tx_data, rdata};
        if (after_rst !== '0) begin
            $display("Fail reset_state outputs expected %h actual %h", 44'h0, after_rst);
            tests_failed++;
            errors++;
        end else begin
            $display("test reset_state passed");
        end

        foreach (lines[i]) begin
            run_test(lines[i]);
        end

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (errors == 0 && tests_failed == 0 && lines.size() > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run length bound from the number of tests
    initial begin
        wait (loaded);
        #((RST_CYCLES + 20 * lines.size() + 2) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule
